// ==== answer_check.sv ====
`timescale 1ns/1ps

module answer_check import digit_board_pkg::*; (
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic [9:0] i_sw,
    input  digit_t     i_digit,
    input  logic       i_digit_valid,
    input  logic       i_identify,
    output digit_t     o_answer,
    output digit_t     o_digit,
    output count_t     o_correct_cnt
);

    localparam count_t CNT_MAX = '1;

    digit_t answer;
    digit_t digit_q;
    digit_t cmp_digit;
    count_t cnt_q;
    logic   hit;

    // highest set switch wins, sw[0] stands for zero
    always_comb begin
        answer = '0;
        for (int i = 1; i < 10; i++) begin
            if (i_sw[i]) begin
                answer = digit_t'(i);
            end
        end
    end

    // a digit arriving with identify is the one compared
    assign cmp_digit = i_digit_valid ? i_digit : digit_q;
    assign hit       = i_identify && (answer == cmp_digit);

    // recogniser result holder
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            digit_q <= '0;
        end else if (i_digit_valid) begin
            digit_q <= i_digit;
        end
    end

    // score, stops at 255
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
        end else if (hit && (cnt_q != CNT_MAX)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign o_answer      = answer;
    assign o_digit       = digit_q;
    assign o_correct_cnt = cnt_q;

    // score only ever grows
    a_cnt_monotonic: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        cnt_q >= $past(cnt_q));

endmodule

// ==== digit_board_pkg.sv ====
package digit_board_pkg;

    // screen position, wide enough for 2048 columns
    typedef logic [10:0] coord_t;
    // one colour channel, 10-bit dac
    typedef logic [9:0]  chan_t;
    // decimal digit from recogniser or switches
    typedef logic [3:0]  digit_t;
    // segments gfedcba, low lights a segment
    typedef logic [6:0]  seg7_t;
    // correct-answer tally
    typedef logic [7:0]  count_t;
    // config register index and write data
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [29:0] cfg_word_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // pixel position plus per-pixel flags
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   frame_start;
    } vga_pos_t;

    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic blank_n;
    } vga_sync_t;

    // scroller settings
    typedef struct packed {
        coord_t step;
        rgb_t   color_a;
        rgb_t   color_b;
    } scroll_cfg_t;

    // register map of scroll_cfg, index 3 unused
    localparam cfg_addr_t CFG_ADDR_STEP    = 2'd0;
    localparam cfg_addr_t CFG_ADDR_COLOR_A = 2'd1;
    localparam cfg_addr_t CFG_ADDR_COLOR_B = 2'd2;

endpackage

// ==== digit_board_top.sv ====
`timescale 1ns/1ps

module digit_board_top import digit_board_pkg::*; #(
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BACK       = 48,
    parameter int V_ACTIVE     = 480,
    parameter int V_FRONT      = 10,
    parameter int V_SYNC       = 2,
    parameter int V_BACK       = 33,
    parameter int STRIPE_SHIFT = 5
) (
    input  logic       i_clk,
    input  logic       i_arst_n,
    // player and recogniser
    input  logic [9:0] i_sw,
    input  digit_t     i_digit,
    input  logic       i_digit_valid,
    input  logic       i_identify,
    // scroller register writes
    input  logic       i_cfg_we,
    input  cfg_addr_t  i_cfg_addr,
    input  cfg_word_t  i_cfg_wdata,
    // vga pins
    output rgb_t       o_rgb,
    output vga_sync_t  o_sync,
    // seven-segment displays
    output seg7_t      o_hex7,
    output seg7_t      o_hex5,
    output seg7_t      o_hex4,
    output seg7_t      o_hex3
);

    vga_pos_t    pos;
    vga_sync_t   timing_sync;
    scroll_cfg_t cfg;
    digit_t      answer;
    digit_t      digit;
    count_t      correct_cnt;

    // screen scan
    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .o_pos    (pos),
        .o_sync   (timing_sync)
    );

    scroll_cfg u_cfg (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg       (cfg)
    );

    // stripes, offset only watched from outside
    scroll_render #(
        .STRIPE_SHIFT (STRIPE_SHIFT)
    ) u_render (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_pos          (pos),
        .i_sync         (timing_sync),
        .i_cfg          (cfg),
        .o_rgb          (o_rgb),
        .o_sync         (o_sync),
        .o_displacement ()
    );

    answer_check u_check (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_sw          (i_sw),
        .i_digit       (i_digit),
        .i_digit_valid (i_digit_valid),
        .i_identify    (i_identify),
        .o_answer      (answer),
        .o_digit       (digit),
        .o_correct_cnt (correct_cnt)
    );

    // recognised digit
    seg7_decoder u_hex7 (.i_hex(digit), .o_seg(o_hex7));
    // score, two hex digits
    seg7_decoder u_hex5 (.i_hex(correct_cnt[7:4]), .o_seg(o_hex5));
    seg7_decoder u_hex4 (.i_hex(correct_cnt[3:0]), .o_seg(o_hex4));
    // player's answer
    seg7_decoder u_hex3 (.i_hex(answer), .o_seg(o_hex3));

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_digit_board -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== scroll_cfg.sv ====
`timescale 1ns/1ps

module scroll_cfg import digit_board_pkg::*; (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_cfg_we,
    input  cfg_addr_t   i_cfg_addr,
    input  cfg_word_t   i_cfg_wdata,
    output scroll_cfg_t o_cfg
);

    // defaults: one pixel per frame, white over black
    localparam coord_t STEP_DEFAULT    = coord_t'(1);
    localparam rgb_t   COLOR_A_DEFAULT = '1;
    localparam rgb_t   COLOR_B_DEFAULT = '0;

    scroll_cfg_t cfg_q;

    // write decode
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cfg_q.step    <= STEP_DEFAULT;
            cfg_q.color_a <= COLOR_A_DEFAULT;
            cfg_q.color_b <= COLOR_B_DEFAULT;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                CFG_ADDR_STEP: begin
                    // only the low bits carry a step
                    cfg_q.step <= i_cfg_wdata[$bits(coord_t)-1:0];
                end
                CFG_ADDR_COLOR_A: begin
                    cfg_q.color_a <= rgb_t'(i_cfg_wdata);
                end
                CFG_ADDR_COLOR_B: begin
                    cfg_q.color_b <= rgb_t'(i_cfg_wdata);
                end
                default: begin
                    // index 3 has no register
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    // settings are a level for the renderer
    assign o_cfg = cfg_q;

endmodule

// ==== scroll_render.sv ====
`timescale 1ns/1ps

module scroll_render import digit_board_pkg::*; #(
    parameter int STRIPE_SHIFT = 5
) (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  vga_pos_t    i_pos,
    input  vga_sync_t   i_sync,
    input  scroll_cfg_t i_cfg,
    output rgb_t        o_rgb,
    output vga_sync_t   o_sync,
    output coord_t      o_displacement
);

    coord_t displacement;
    coord_t stripe_sum;
    logic   stripe_bit;
    rgb_t   rgb_c;

    // scroll offset, moves once per frame
    // 11-bit add wraps at 2048 on its own
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            displacement <= '0;
        end else if (i_pos.frame_start) begin
            displacement <= displacement + i_cfg.step;
        end
    end

    // stripe phase uses the offset before this cycle's update
    assign stripe_sum = i_pos.x + displacement;
    assign stripe_bit = stripe_sum[STRIPE_SHIFT];

    // colour select
    always_comb begin
        if (!i_pos.active) begin
            rgb_c = '0;
        end else if (stripe_bit) begin
            rgb_c = i_cfg.color_a;
        end else begin
            rgb_c = i_cfg.color_b;
        end
    end

    // one register stage, sync delayed alongside
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rgb  <= '0;
            o_sync <= '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0};
        end else begin
            o_rgb  <= rgb_c;
            o_sync <= i_sync;
        end
    end

    assign o_displacement = displacement;

    // blank from timing and colour from active must agree after the delay
    a_black_in_blank: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !o_sync.blank_n |-> (o_rgb == '0));

endmodule

// ==== seg7_decoder.sv ====
`timescale 1ns/1ps

module seg7_decoder import digit_board_pkg::*; (
    input  logic [3:0] i_hex,
    output seg7_t      o_seg
);

    // gfedcba, 0 lights the segment
    always_comb begin
        case (i_hex)
            4'h0: o_seg = 7'b1000000;
            4'h1: o_seg = 7'b1111001;
            4'h2: o_seg = 7'b0100100;
            4'h3: o_seg = 7'b0110000;
            4'h4: o_seg = 7'b0011001;
            4'h5: o_seg = 7'b0010010;
            4'h6: o_seg = 7'b0000010;
            4'h7: o_seg = 7'b1111000;
            4'h8: o_seg = 7'b0000000;
            4'h9: o_seg = 7'b0010000;
            // letters, b and d in lower case
            4'ha: o_seg = 7'b0001000;
            4'hb: o_seg = 7'b0000011;
            4'hc: o_seg = 7'b1000110;
            4'hd: o_seg = 7'b0100001;
            4'he: o_seg = 7'b0000110;
            default: o_seg = 7'b0001110;
        endcase
    end

endmodule

// ==== sources.f ====
digit_board_pkg.sv
vga_timing.sv
scroll_cfg.sv
scroll_render.sv
answer_check.sv
seg7_decoder.sv
digit_board_top.sv
tb_digit_board.sv

// ==== tb_digit_board.sv ====
`timescale 1ns/1ps

module tb_digit_board import digit_board_pkg::*; ();

    // small screen so that a frame is only 240 clocks
    localparam int H_ACTIVE       = 16;
    localparam int H_FRONT        = 2;
    localparam int H_SYNC         = 3;
    localparam int H_BACK         = 3;
    localparam int V_ACTIVE       = 6;
    localparam int V_FRONT        = 1;
    localparam int V_SYNC         = 2;
    localparam int V_BACK         = 1;
    localparam int STRIPE_SHIFT   = 2;
    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 400;

    logic        i_clk;
    logic        i_arst_n;
    logic [9:0]  i_sw;
    digit_t      i_digit;
    logic        i_digit_valid;
    logic        i_identify;
    logic        i_cfg_we;
    cfg_addr_t   i_cfg_addr;
    cfg_word_t   i_cfg_wdata;
    rgb_t        o_rgb;
    vga_sync_t   o_sync;
    seg7_t       o_hex7;
    seg7_t       o_hex5;
    seg7_t       o_hex4;
    seg7_t       o_hex3;

    // model state, values after the latest rising edge
    scroll_cfg_t m_cfg;
    coord_t      m_disp;
    digit_t      m_digit;
    count_t      m_cnt;
    rgb_t        exp_rgb;
    vga_sync_t   exp_sync;
    int          edge_cnt;
    logic        model_ready = 1'b0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state;
    string       test_name;

    digit_board_top #(
        .H_ACTIVE     (H_ACTIVE),
        .H_FRONT      (H_FRONT),
        .H_SYNC       (H_SYNC),
        .H_BACK       (H_BACK),
        .V_ACTIVE     (V_ACTIVE),
        .V_FRONT      (V_FRONT),
        .V_SYNC       (V_SYNC),
        .V_BACK       (V_BACK),
        .STRIPE_SHIFT (STRIPE_SHIFT)
    ) DUT (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_sw          (i_sw),
        .i_digit       (i_digit),
        .i_digit_valid (i_digit_valid),
        .i_identify    (i_identify),
        .i_cfg_we      (i_cfg_we),
        .i_cfg_addr    (i_cfg_addr),
        .i_cfg_wdata   (i_cfg_wdata),
        .o_rgb         (o_rgb),
        .o_sync        (o_sync),
        .o_hex7        (o_hex7),
        .o_hex5        (o_hex5),
        .o_hex4        (o_hex4),
        .o_hex3        (o_hex3)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // sync and blank for scan index idx of a frame
    function automatic vga_sync_t sync_at(input int idx);
        int        x;
        int        y;
        vga_sync_t s;
        x = idx % H_TOTAL;
        y = idx / H_TOTAL;
        s.hsync_n = !((x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC));
        s.vsync_n = !((y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC));
        s.blank_n = (x < H_ACTIVE) && (y < V_ACTIVE);
        return s;
    endfunction

    // stripe bit of (x + offset) mod 2048 picks color_a or color_b
    function automatic rgb_t stripe_colour(input int idx, input coord_t disp,
                                           input scroll_cfg_t cfg);
        int x;
        int y;
        int phase;
        x = idx % H_TOTAL;
        y = idx / H_TOTAL;
        phase = (x + int'(disp)) % 2048;
        if ((x >= H_ACTIVE) || (y >= V_ACTIVE)) return '0;
        if (((phase >> STRIPE_SHIFT) & 1) == 1) return cfg.color_a;
        return cfg.color_b;
    endfunction

    // sw[0] alone or nothing set means zero
    function automatic digit_t highest_switch(input logic [9:0] sw);
        for (int i = 9; i >= 1; i--) begin
            if (sw[i]) return digit_t'(i);
        end
        return 4'd0;
    endfunction

    function automatic count_t next_count(input count_t cnt, input logic identify,
                                          input digit_t answer, input digit_t shown);
        if (identify && (answer == shown) && (cnt != 8'd255)) return cnt + 8'd1;
        return cnt;
    endfunction

    // lit segments gfedcba, inverted for the active-low pins
    function automatic seg7_t seg_pattern(input logic [3:0] hex);
        seg7_t lit;
        case (hex)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // index 3 leaves the registers alone
    function automatic scroll_cfg_t apply_cfg_write(input scroll_cfg_t cfg,
                                                    input cfg_addr_t addr, input cfg_word_t data);
        scroll_cfg_t c;
        c = cfg;
        if (addr == 2'd0) begin
            c.step = data[10:0];
        end else if (addr == 2'd1) begin
            c.color_a = data;
        end else if (addr == 2'd2) begin
            c.color_b = data;
        end
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // scan index of the pixel on the pins is edge_cnt - 2
    always @(posedge i_clk) begin
        model_ready = 1'b1;
        if (!i_arst_n) begin
            edge_cnt      = 0;
            m_disp        = '0;
            m_cfg.step    = 11'd1;
            m_cfg.color_a = '1;
            m_cfg.color_b = '0;
            m_digit       = '0;
            m_cnt         = '0;
            exp_rgb       = '0;
            exp_sync      = '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0};
        end else begin
            edge_cnt = edge_cnt + 1;
            if (edge_cnt >= 2) begin
                exp_sync = sync_at((edge_cnt - 2) % FRAME_CYCLES);
                exp_rgb  = stripe_colour((edge_cnt - 2) % FRAME_CYCLES, m_disp, m_cfg);
                // offset moves after the first pixel of the frame
                if ((edge_cnt - 2) % FRAME_CYCLES == 0) m_disp = m_disp + m_cfg.step;
            end
            m_cnt = next_count(m_cnt, i_identify, highest_switch(i_sw),
                               i_digit_valid ? i_digit : m_digit);
            if (i_digit_valid) m_digit = i_digit;
            if (i_cfg_we) m_cfg = apply_cfg_write(m_cfg, i_cfg_addr, i_cfg_wdata);
        end
    end

    // compare on the falling edge, away from input changes
    always @(negedge i_clk) begin
        if (model_ready) begin
            check_value({test_name, " rgb"}, 32'(exp_rgb), 32'(o_rgb));
            check_value({test_name, " sync"}, 32'(exp_sync), 32'(o_sync));
            check_value({test_name, " hex7"}, 32'(seg_pattern(m_digit)), 32'(o_hex7));
            check_value({test_name, " hex5"}, 32'(seg_pattern(m_cnt[7:4])), 32'(o_hex5));
            check_value({test_name, " hex4"}, 32'(seg_pattern(m_cnt[3:0])), 32'(o_hex4));
            check_value({test_name, " hex3"}, 32'(seg_pattern(highest_switch(i_sw))),
                        32'(o_hex3));
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run passed %0d cycles in test %s", cycle_cnt, test_name);
            $display("RESULT: FAIL");
            $fatal(1, "simulation did not finish");
        end
    end

    initial begin
        int pick;
        test_name     = "reset";
        rng_state     = 32'h0e18_1c4f;
        i_arst_n      <= 1'b0;
        i_sw          <= '0;
        i_digit       <= '0;
        i_digit_valid <= 1'b0;
        i_identify    <= 1'b0;
        i_cfg_we      <= 1'b0;
        i_cfg_addr    <= '0;
        i_cfg_wdata   <= '0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        check_value("reset sync lines", 32'd3, 32'({o_sync.hsync_n, o_sync.vsync_n}));
        check_value("reset count", 32'(seg_pattern(4'h0)), 32'(o_hex4));
        @(posedge i_clk);
        i_arst_n <= 1'b1;

        // two frames with the default scroller settings
        test_name = "frames_default";
        repeat (2 * FRAME_CYCLES + 4) @(posedge i_clk);

        // writes land at random points of the scan
        test_name = "frames_cfg";
        for (int w = 0; w < 8; w++) begin
            @(posedge i_clk);
            rng_state = xorshift32(rng_state);
            i_cfg_we    <= 1'b1;
            i_cfg_addr  <= cfg_addr_t'(w % 4);
            i_cfg_wdata <= cfg_word_t'(rng_state);
            @(posedge i_clk);
            i_cfg_we <= 1'b0;
            repeat (rng_state[4:0]) @(posedge i_clk);
        end
        repeat (3 * FRAME_CYCLES) @(posedge i_clk);

        test_name = "switches";
        for (int n = 0; n < 40; n++) begin
            @(posedge i_clk);
            rng_state = xorshift32(rng_state);
            i_sw <= rng_state[9:0] >> rng_state[13:10];
        end

        // strobes and pulses, often on the same cycle
        test_name = "identify";
        for (int n = 0; n < 200; n++) begin
            @(posedge i_clk);
            rng_state = xorshift32(rng_state);
            pick = int'(rng_state[11:8]) % 10;
            i_digit_valid <= rng_state[0];
            i_identify    <= rng_state[1];
            i_digit       <= rng_state[2] ? digit_t'(pick) : digit_t'(int'(rng_state[7:4]) % 10);
            // top switch at pick, noise below it
            i_sw <= (10'd1 << pick) | (rng_state[21:12] & ((10'd1 << pick) - 10'd1));
        end
        @(posedge i_clk);
        i_digit_valid <= 1'b0;
        i_identify    <= 1'b0;

        // answer 5 against digit 5, far past the top of the count
        test_name = "saturate";
        @(posedge i_clk);
        i_sw          <= 10'b00_0010_0000;
        i_digit       <= 4'd5;
        i_digit_valid <= 1'b1;
        @(posedge i_clk);
        i_digit_valid <= 1'b0;
        for (int n = 0; n < 300; n++) begin
            @(posedge i_clk);
            i_identify <= 1'b1;
            @(posedge i_clk);
            i_identify <= 1'b0;
        end
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_value("saturate high nibble", 32'(seg_pattern(4'hf)), 32'(o_hex5));
        check_value("saturate low nibble", 32'(seg_pattern(4'hf)), 32'(o_hex4));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing import digit_board_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic      i_clk,
    input  logic      i_arst_n,
    output vga_pos_t  o_pos,
    output vga_sync_t o_sync
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    coord_t x_cnt;
    coord_t y_cnt;
    logic   x_wrap;
    logic   y_wrap;
    logic   active_c;
    logic   hsync_n_c;
    logic   vsync_n_c;

    assign x_wrap = (x_cnt == coord_t'(H_TOTAL - 1));
    assign y_wrap = (y_cnt == coord_t'(V_TOTAL - 1));

    // scan counters, y steps once per line
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_wrap) begin
            x_cnt <= '0;
            y_cnt <= y_wrap ? '0 : y_cnt + 1'b1;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    // decode of the current count
    assign active_c  = (x_cnt < coord_t'(H_ACTIVE)) && (y_cnt < coord_t'(V_ACTIVE));
    assign hsync_n_c = !((x_cnt >= coord_t'(H_SYNC_START)) && (x_cnt < coord_t'(H_SYNC_END)));
    assign vsync_n_c = !((y_cnt >= coord_t'(V_SYNC_START)) && (y_cnt < coord_t'(V_SYNC_END)));

    // output stage, one cycle behind the counters
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pos  <= '0;
            o_sync <= '{hsync_n: 1'b1, vsync_n: 1'b1, blank_n: 1'b0};
        end else begin
            o_pos.x           <= x_cnt;
            o_pos.y           <= y_cnt;
            o_pos.active      <= active_c;
            o_pos.frame_start <= (x_cnt == '0) && (y_cnt == '0);
            o_sync.hsync_n    <= hsync_n_c;
            o_sync.vsync_n    <= vsync_n_c;
            o_sync.blank_n    <= active_c;
        end
    end

    // counter never leaves the line
    a_x_in_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        x_cnt < coord_t'(H_TOTAL));

    // no horizontal sync pulse inside the picture
    a_hsync_idle_active: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pos.active |-> o_sync.hsync_n);

endmodule
